// ==== files.f ====
logic/klLoadPkg.sv
logic/loadLineDecoder.sv
logic/fieldCounter.sv
logic/loadLineSequencer.sv
logic/ramWordAssembler.sv
logic/microcodeLoader.sv
sim/clockGen.sv
sim/microcodeLoaderTb.sv

// ==== Bender.yml ====
package:
  name: microcodeLoader

sources:
  - logic/klLoadPkg.sv
  - logic/loadLineDecoder.sv
  - logic/fieldCounter.sv
  - logic/loadLineSequencer.sv
  - logic/ramWordAssembler.sv
  - logic/microcodeLoader.sv
  - target: test
    files:
      - sim/clockGen.sv
      - sim/microcodeLoaderTb.sv

// ==== sim/microcodeLoaderTb.sv ====
// Loader testbench: line table, character driver, write/status monitor and watchdog
module microcodeLoaderTb import klLoadPkg::*; ();

  localparam int NumLines     = 13;
  localparam int MaxFields    = 42;
  // Character to write or status, end to end through the top level
  localparam int Latency      = 3;
  localparam int CramPerLine  = 5;
  localparam int DramPerLine  = 10;
  localparam tLoadChar CharLf    = 7'h0a;
  localparam tLoadChar CharCr    = 7'h0d;
  localparam tLoadChar CharSpace = 7'h20;
  localparam tLoadChar CharComma = 7'h2c;

  // Expected write or status with the cycle it must show up in
  typedef struct packed {
    logic [7:0]   line;
    logic [31:0]  cycle;
    logic [127:0] value;
  } tExpect;

  logic       clk;
  logic       reset;
  tCharStrobe charIn;
  tCramWrite  cramWrite;
  tDramWrite  dramWrite;
  tLineStatus lineStatus;

  // Line table, one entry per load line
  string      lineName [NumLines];
  byte        lineLetter [NumLines];
  string      lineRaw [NumLines];
  int         lineWc [NumLines];
  int         lineAddr [NumLines];
  int         lineData [NumLines];
  int         lineCorrupt [NumLines];
  bit         lineExtra [NumLines];
  bit         lineFormat [NumLines];

  // Fields as sent, filled before the run
  tLoadWord   lineWords [NumLines][MaxFields];
  int         lineFields [NumLines];
  bit         lineChecksumError [NumLines];

  logic [31:0] lfsrState = 32'h59ee7125;
  int          cycle = 0;
  int          errorCount = 0;
  int          checkCount = 0;
  int          tableSize = 0;
  int          totalChars = 0;
  int          watchCycles = 0;

  tExpect cramExp [$];
  tExpect dramExp [$];
  tExpect statusExp [$];

  clockGen #(.Period(8)) clockSource (.clk);

  microcodeLoader #(
    .MaxCramPerLine     (CramPerLine),
    .MaxDramPairsPerLine(DramPerLine)
  ) uut (
    .clk, .reset, .charIn, .cramWrite, .dramWrite, .lineStatus
  );

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] nextLfsr(logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic randomBits(input int count, output logic [31:0] value);
    int n;
    value = '0;
    for (n = 0; n < count; n++) begin
      value = {value[30:0], lfsrState[0]};
      lfsrState = nextLfsr(lfsrState);
    end
  endtask

  // Six data bits per character; 077 would be DEL so it uses '?'
  function automatic tLoadChar fieldChar(logic [5:0] bits);
    return (bits == 6'o77) ? 7'h3f : {1'b1, bits};
  endfunction

  // A, B, P, then J as common J01-J04, two zeros, own J07-J10
  function automatic logic [16:0] dramSide(tLoadWord side, tLoadWord common);
    return {side[13:11], side[10:8], side[5], common[3:0], 2'b00, side[3:0]};
  endfunction

  task automatic compareValue(input string testName, input logic [127:0] expected,
                              input logic [127:0] actual);
    checkCount++;
    if (expected !== actual) begin
      errorCount++;
      $display("error %s: expected %0h, actual %0h", testName, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Line table

  task automatic defineLine(input string name, input byte letter, input string raw,
                            input int wc, input int addr, input int dataCount,
                            input int corrupt, input bit extra, input bit formatError);
    lineName[tableSize] = name;
    lineLetter[tableSize] = letter;
    lineRaw[tableSize] = raw;
    lineWc[tableSize] = wc;
    lineAddr[tableSize] = addr;
    lineData[tableSize] = dataCount;
    lineCorrupt[tableSize] = corrupt;
    lineExtra[tableSize] = extra;
    lineFormat[tableSize] = formatError;
    tableSize++;
  endtask

  task automatic loadTable();
    // Name, letter, raw text, WC, address, data words sent, checksum xor, extra, format
    defineLine("comment", ";", "; KL10 microcode load file\015\n", 0, 0, 0, 0, 0, 0);
    defineLine("cramTwoGroups", "C", "", 12, 'h123, 12, 0, 0, 0);
    defineLine("dramThreePairs", "D", "", 9, 'h040, 9, 0, 0, 0);
    defineLine("cramBadChecksum", "C", "", 6, 'h7fe, 6, 'h0010, 0, 0);
    defineLine("dramBadChecksum", "D", "", 3, 'h1fe, 3, 'h8000, 0, 0);
    defineLine("cramPartialGroup", "C", "", 8, 'h200, 8, 0, 0, 1);
    defineLine("dramPartialGroup", "D", "", 4, 'h010, 4, 0, 0, 1);
    defineLine("cramTooLong", "C", "", 36, 'h300, 36, 0, 0, 1);
    defineLine("dramEndsEarly", "D", "", 6, 'h020, 3, 0, 0, 1);
    defineLine("cramExtraWord", "C", "", 6, 'h010, 6, 0, 1, 1);
    defineLine("unknownLetter", "Z", "Z 1,2,3\n", 0, 0, 0, 0, 0, 0);
    defineLine("cramEnd", "C", "C ,,\015\n", 0, 0, 0, 0, 0, 0);
    // CR ahead of the letter
    defineLine("dramEnd", "D", "\015D ,,\n", 0, 0, 0, 0, 0, 0);
  endtask

  // Random data, checksum, extra word and exact character count per line
  task automatic buildLines();
    int line;
    int k;
    int count;
    logic [31:0] value;
    tLoadWord sum;
    for (line = 0; line < tableSize; line++) begin
      if (lineRaw[line].len() > 0) begin
        lineFields[line] = 0;
        totalChars += lineRaw[line].len();
      end else begin
        lineWords[line][0] = tLoadWord'(lineWc[line]);
        lineWords[line][1] = tLoadWord'(lineAddr[line]);
        sum = lineWords[line][0] + lineWords[line][1];
        count = 2;
        for (k = 0; k < lineData[line]; k++) begin
          randomBits(16, value);
          lineWords[line][count] = value[15:0];
          sum += value[15:0];
          count++;
        end
        // Checksum only follows a complete data section
        if (lineData[line] == lineWc[line]) begin
          lineWords[line][count] = (-sum) ^ tLoadWord'(lineCorrupt[line]);
          count++;
        end
        if (lineExtra[line]) begin
          lineWords[line][count] = '0;
          count++;
        end
        lineFields[line] = count;
        // Letter, space, CR, one separator per field, three chars per nonzero word
        totalChars += 3 + count;
        sum = '0;
        for (k = 0; k < count; k++) begin
          sum += lineWords[line][k];
          if (lineWords[line][k] != '0) begin
            totalChars += 3;
          end
        end
        lineChecksumError[line] = sum != '0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Character driver

  // Zero to three idle cycles, then one strobe
  task automatic sendChar(input tLoadChar ch, output int sentCycle);
    logic [31:0] gap;
    randomBits(2, gap);
    repeat (gap) begin
      @(posedge clk);
      #1;
      charIn = '0;
    end
    @(posedge clk);
    #1;
    charIn = '{valid: 1'b1, ch: ch};
    sentCycle = cycle;
  endtask

  task automatic sendLine(input int line);
    int k;
    int n;
    int d;
    int g;
    int groupSize;
    int sentCycle;
    byte rawChar;
    tLoadWord word;
    tLoadWord grp [CramGroupWords];
    tExpect entry;
    tRecordKind kind;
    kind = (lineLetter[line] == "D") ? recDram : recCram;
    groupSize = (kind == recDram) ? DramGroupWords : CramGroupWords;
    entry.line = 8'(line);
    if (lineRaw[line].len() > 0) begin
      for (k = 0; k < lineRaw[line].len(); k++) begin
        rawChar = lineRaw[line].getc(k);
        sendChar(rawChar[6:0], sentCycle);
      end
    end else begin
      sendChar(tLoadChar'(lineLetter[line]), sentCycle);
      sendChar(CharSpace, sentCycle);
      for (k = 0; k < lineFields[line]; k++) begin
        word = lineWords[line][k];
        // Zero goes out as an empty field
        if (word != '0) begin
          sendChar(fieldChar({2'b00, word[15:12]}), sentCycle);
          sendChar(fieldChar(word[11:6]), sentCycle);
          sendChar(fieldChar(word[5:0]), sentCycle);
        end
        if (k == lineFields[line] - 1) begin
          sendChar(CharCr, sentCycle);
          sendChar(CharLf, sentCycle);
        end else begin
          sendChar(CharComma, sentCycle);
        end
        // Data word that closes a group triggers a write
        d = k - 2;
        if (d >= 0 && d < lineData[line] && (d + 1) % groupSize == 0) begin
          g = d / groupSize;
          for (n = 0; n < groupSize; n++) begin
            grp[n] = lineWords[line][k - groupSize + 1 + n];
          end
          entry.cycle = sentCycle + Latency;
          if (kind == recCram) begin
            // Bits 0-15 first, sixth word fills 80-85
            entry.value = {tCramAddr'(lineAddr[line] + g), grp[4], grp[3], grp[2],
                           grp[1], grp[0], grp[5][5:0]};
            cramExp.push_back(entry);
          end else begin
            entry.value = {tDramAddr'(lineAddr[line] + 2 * g),
                           dramSide(grp[0], grp[2]), dramSide(grp[1], grp[2])};
            dramExp.push_back(entry);
          end
        end
      end
    end
    // Only C and D lines report, counted from the LF
    if (lineLetter[line] == "C" || lineLetter[line] == "D") begin
      entry.cycle = sentCycle + Latency;
      entry.value = {kind, lineChecksumError[line], lineFormat[line]};
      statusExp.push_back(entry);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled on the falling edge

  always @(negedge clk) begin : monitor
    tExpect entry;
    if (!reset && cramWrite.valid) begin
      if (cramExp.size() == 0) begin
        errorCount++;
        $display("unexpected CRAM write to %h at cycle %0d", cramWrite.addr, cycle);
      end else begin
        entry = cramExp.pop_front();
        compareValue({lineName[entry.line], " CRAM write"}, entry.value,
                     {cramWrite.addr, cramWrite.data});
        compareValue({lineName[entry.line], " CRAM cycle"}, entry.cycle, cycle);
      end
    end
    if (!reset && dramWrite.valid) begin
      if (dramExp.size() == 0) begin
        errorCount++;
        $display("unexpected DRAM write to %h at cycle %0d", dramWrite.addr, cycle);
      end else begin
        entry = dramExp.pop_front();
        compareValue({lineName[entry.line], " DRAM write"}, entry.value,
                     {dramWrite.addr, dramWrite.even, dramWrite.odd});
        compareValue({lineName[entry.line], " DRAM cycle"}, entry.cycle, cycle);
      end
    end
    if (!reset && lineStatus.valid) begin
      if (statusExp.size() == 0) begin
        errorCount++;
        $display("unexpected line status at cycle %0d", cycle);
      end else begin
        entry = statusExp.pop_front();
        compareValue({lineName[entry.line], " status"}, entry.value,
                     {lineStatus.kind, lineStatus.checksumError, lineStatus.formatError});
        compareValue({lineName[entry.line], " status cycle"}, entry.cycle, cycle);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog and main sequence

  // At most four cycles per character, plus reset and drain
  initial begin : watchdog
    wait (watchCycles > 0);
    repeat (watchCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the load did not finish", watchCycles);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    int line;
    int missing;
    charIn = '0;
    reset = 1'b1;
    loadTable();
    buildLines();
    watchCycles = totalChars * 5 + 100;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    for (line = 0; line < tableSize; line++) begin
      sendLine(line);
    end
    @(posedge clk);
    #1;
    charIn = '0;
    // Last write or status lands three cycles after the final LF
    repeat (Latency + 1) @(posedge clk);
    missing = cramExp.size() + dramExp.size() + statusExp.size();
    if (missing != 0) begin
      errorCount++;
      $display("%0d expected writes or statuses never arrived", missing);
    end
    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim/clockGen.sv ====
// Free-running testbench clock source
module clockGen #(
  parameter int Period = 8
) (
  output logic clk
);

  initial clk = 1'b0;

  // Half period low, half period high
  always #(Period / 2) clk = ~clk;

endmodule

// ==== logic/microcodeLoader.sv ====
// Microcode loader top level: decoder, field counter, sequencer and assembler
module microcodeLoader import klLoadPkg::*; #(
  parameter int MaxCramPerLine      = 5,
  parameter int MaxDramPairsPerLine = 10
) (
  input  logic       clk,
  input  logic       reset,
  input  tCharStrobe charIn,
  output tCramWrite  cramWrite,
  output tDramWrite  dramWrite,
  output tLineStatus lineStatus
);

  // Decoder outputs
  logic       lineStart;
  tRecordKind lineKind;
  tWordStrobe wordOut;
  logic       checksumOk;

  // Counter outputs
  logic [1:0] fieldIndex;
  logic [2:0] groupSlot;
  logic       groupDone;
  logic       countError;

  // Sequencer strobes to the assembler
  logic       loadStrobe;
  logic       storeAddr;
  logic       emitCram;
  logic       emitDram;

  loadLineDecoder lineDecoder (
    .clk, .reset, .charIn, .lineStart, .lineKind, .wordOut, .checksumOk
  );

  fieldCounter #(
    .MaxCramPerLine     (MaxCramPerLine),
    .MaxDramPairsPerLine(MaxDramPairsPerLine)
  ) counter (
    .clk, .reset, .lineStart, .lineKind, .wordOut,
    .fieldIndex, .groupSlot, .groupDone, .countError
  );

  loadLineSequencer sequencer (
    .clk, .reset, .lineStart, .lineKind, .wordOut, .checksumOk,
    .fieldIndex, .groupDone, .countError,
    .loadStrobe, .storeAddr, .emitCram, .emitDram, .lineStatus
  );

  ramWordAssembler assembler (
    .clk, .reset, .wordOut, .groupSlot,
    .loadStrobe, .storeAddr, .emitCram, .emitDram,
    .cramWrite, .dramWrite
  );

endmodule

// ==== logic/ramWordAssembler.sv ====
// CRAM word and DRAM pair assembly with write address stepping
module ramWordAssembler import klLoadPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  tWordStrobe wordOut,
  input  logic [2:0] groupSlot,
  input  logic       loadStrobe,
  input  logic       storeAddr,
  input  logic       emitCram,
  input  logic       emitDram,
  output tCramWrite  cramWrite,
  output tDramWrite  dramWrite
);

  tLoadWord   wordQ;
  logic [2:0] slotQ;
  // Words of the group before the last one
  tLoadWord   slotWord [CramGroupWords-1];
  tCramAddr   cramAddr;
  tDramAddr   dramAddr;
  tCramWord   cramData;
  tDramEntry  evenEntry;
  tDramEntry  oddEntry;
  logic       cramValidQ;
  logic       dramValidQ;
  tCramAddr   cramAddrQ;
  tCramWord   cramDataQ;
  tDramAddr   dramAddrQ;
  tDramEntry  evenQ;
  tDramEntry  oddQ;

  // A, B and P from the side word, J joins common and side bits
  function automatic tDramEntry makeEntry(tLoadWord side, tLoadWord common);
    tDramEntry entry;
    entry.a = side[13:11];
    entry.b = side[10:8];
    entry.p = side[5];
    entry.j = {common[3:0], 2'b00, side[3:0]};
    return entry;
  endfunction

  // Word and slot line up with the registered strobes
  always_ff @(posedge clk) begin
    if (wordOut.valid) begin
      wordQ <= wordOut.word;
      slotQ <= groupSlot;
    end
    if (loadStrobe) slotWord[slotQ] <= wordQ;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Location layout

  always_comb begin
    cramData[64:79] = slotWord[0];
    cramData[48:63] = slotWord[1];
    cramData[32:47] = slotWord[2];
    cramData[16:31] = slotWord[3];
    cramData[0:15] = slotWord[4];
    // Special field, CALL and DISP
    cramData[80:85] = wordQ[5:0];
    // Common word is the last of a DRAM group
    evenEntry = makeEntry(slotWord[0], wordQ);
    oddEntry = makeEntry(slotWord[1], wordQ);
  end

  // Line address, then one step per write
  always_ff @(posedge clk) begin
    if (storeAddr) begin
      cramAddr <= tCramAddr'(wordQ);
      dramAddr <= {wordQ[8:1], 1'b0};
    end else begin
      if (emitCram) cramAddr <= cramAddr + tCramAddr'(1);
      if (emitDram) dramAddr <= dramAddr + tDramAddr'(2);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write outputs

  always_ff @(posedge clk) begin
    if (reset) begin
      cramValidQ <= 1'b0;
      dramValidQ <= 1'b0;
    end else begin
      cramValidQ <= emitCram;
      dramValidQ <= emitDram;
    end
  end

  always_ff @(posedge clk) begin
    if (emitCram) begin
      cramAddrQ <= cramAddr;
      cramDataQ <= cramData;
    end
    if (emitDram) begin
      dramAddrQ <= dramAddr;
      evenQ <= evenEntry;
      oddQ <= oddEntry;
    end
  end

  assign cramWrite = '{valid: cramValidQ, addr: cramAddrQ, data: cramDataQ};
  assign dramWrite = '{valid: dramValidQ, addr: dramAddrQ, even: evenQ, odd: oddQ};

endmodule

// ==== logic/loadLineSequencer.sv ====
// Word role FSM raising load, address and write strobes and the line status
module loadLineSequencer import klLoadPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       lineStart,
  input  tRecordKind lineKind,
  input  tWordStrobe wordOut,
  input  logic       checksumOk,
  input  logic [1:0] fieldIndex,
  input  logic       groupDone,
  input  logic       countError,
  output logic       loadStrobe,
  output logic       storeAddr,
  output logic       emitCram,
  output logic       emitDram,
  output tLineStatus lineStatus
);

  typedef enum logic [2:0] {
    sIdle,
    sWordCount,
    sAddress,
    sData,
    // Checksum taken, only the line end is legal from here
    sChecksum,
    sSkip
  } tSeqState;

  tSeqState   state;
  tSeqState   nextState;
  tRecordKind kindQ;
  logic       loadNext;
  logic       storeNext;
  logic       emitNext;
  logic       tookChecksum;
  logic       lineEnd;
  logic       inLine;
  tLineStatus statusNext;
  tLineStatus statusQ;

  ////////////////////////////////////////////////////////////////////////////
  // Word routing

  always_comb begin
    nextState = state;
    loadNext = 1'b0;
    storeNext = 1'b0;
    emitNext = 1'b0;
    tookChecksum = 1'b0;
    lineEnd = 1'b0;
    inLine = state inside {sWordCount, sAddress, sData, sChecksum};
    if (lineStart) begin
      // A new letter always restarts, even mid line
      nextState = (lineKind == recSkip) ? sSkip : sWordCount;
    end else if (wordOut.valid) begin
      case (state)
        sWordCount: nextState = sAddress;
        sAddress: begin
          storeNext = 1'b1;
          nextState = sData;
        end
        sData: begin
          if (fieldIndex == FieldData) begin
            // Last word of a group goes out with the write
            loadNext = !groupDone;
            emitNext = groupDone;
          end else begin
            tookChecksum = 1'b1;
            nextState = sChecksum;
          end
        end
        default: ;
      endcase
      if (wordOut.lastInLine && inLine) begin
        lineEnd = 1'b1;
        nextState = sIdle;
      end
    end
    // Early end, extra word after the checksum, or bad WC
    statusNext = '{
      valid: lineEnd,
      kind: kindQ,
      checksumError: !checksumOk,
      formatError: !tookChecksum || countError
    };
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe and status registers

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sIdle;
      kindQ <= recSkip;
      loadStrobe <= 1'b0;
      storeAddr <= 1'b0;
      emitCram <= 1'b0;
      emitDram <= 1'b0;
      statusQ <= '0;
      lineStatus <= '0;
    end else begin
      state <= nextState;
      if (lineStart) kindQ <= lineKind;
      loadStrobe <= loadNext;
      storeAddr <= storeNext;
      emitCram <= emitNext && kindQ == recCram;
      emitDram <= emitNext && kindQ == recDram;
      // Extra stage keeps the status level with the final write
      statusQ <= statusNext;
      lineStatus <= statusQ;
    end
  end

  assert property (@(posedge clk) disable iff (reset) !(emitCram && emitDram));

endmodule

// ==== logic/fieldCounter.sv ====
// Field phase, group slot and word count tracking for one load line
module fieldCounter import klLoadPkg::*; #(
  parameter int MaxCramPerLine      = 5,
  parameter int MaxDramPairsPerLine = 10
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       lineStart,
  input  tRecordKind lineKind,
  input  tWordStrobe wordOut,
  output logic [1:0] fieldIndex,
  output logic [2:0] groupSlot,
  output logic       groupDone,
  output logic       countError
);

  // Largest legal WC per record kind
  localparam tLoadWord CramWordLimit = tLoadWord'(MaxCramPerLine * CramGroupWords);
  localparam tLoadWord DramWordLimit = tLoadWord'(MaxDramPairsPerLine * DramGroupWords);
  localparam logic [2:0] CramLastSlot = 3'(CramGroupWords - 1);
  localparam logic [2:0] DramLastSlot = 3'(DramGroupWords - 1);

  tRecordKind kindQ;
  logic       haveWc;
  tLoadWord   wcLeft;
  tLoadWord   wordLimit;
  logic [2:0] lastSlot;
  logic [2:0] nextSlot;

  always_comb begin
    lastSlot = (kindQ == recDram) ? DramLastSlot : CramLastSlot;
    wordLimit = (kindQ == recDram) ? DramWordLimit : CramWordLimit;
    nextSlot = (groupSlot == lastSlot) ? 3'd0 : groupSlot + 3'd1;
    groupDone = wordOut.valid && fieldIndex == FieldData && groupSlot == lastSlot;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      kindQ <= recSkip;
      haveWc <= 1'b0;
      fieldIndex <= FieldAddress;
      groupSlot <= '0;
      countError <= 1'b0;
    end else if (lineStart) begin
      kindQ <= lineKind;
      haveWc <= 1'b0;
      fieldIndex <= FieldAddress;
      groupSlot <= '0;
      countError <= 1'b0;
    end else if (wordOut.valid) begin
      case (fieldIndex)
        FieldAddress: begin
          if (!haveWc) begin
            // WC word, check against the line size
            haveWc <= 1'b1;
            if (wordOut.word > wordLimit) countError <= 1'b1;
          end else begin
            // Address word, WC zero goes straight to the checksum
            fieldIndex <= (wcLeft == '0) ? FieldChecksum : FieldData;
          end
        end
        FieldData: begin
          groupSlot <= nextSlot;
          if (wcLeft == 16'd1) begin
            fieldIndex <= FieldChecksum;
            // Partial last group
            if (nextSlot != 3'd0) countError <= 1'b1;
          end
        end
        FieldChecksum: fieldIndex <= FieldOverflow;
        default: ;
      endcase
    end
  end

  // Remaining data words
  always_ff @(posedge clk) begin
    if (wordOut.valid && fieldIndex == FieldAddress && !haveWc) begin
      wcLeft <= wordOut.word;
    end else if (wordOut.valid && fieldIndex == FieldData) begin
      wcLeft <= wcLeft - 16'd1;
    end
  end

  assert property (@(posedge clk) disable iff (reset) groupSlot < 3'(CramGroupWords));

endmodule

// ==== logic/loadLineDecoder.sv ====
// Character to word decoder with record letter detection and line checksum
module loadLineDecoder import klLoadPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  tCharStrobe charIn,
  output logic       lineStart,
  output tRecordKind lineKind,
  output tWordStrobe wordOut,
  output logic       checksumOk
);

  localparam tLoadChar CharLf    = 7'h0a;
  localparam tLoadChar CharSpace = 7'h20;
  localparam tLoadChar CharComma = 7'h2c;
  localparam tLoadChar CharC     = 7'h43;
  localparam tLoadChar CharD     = 7'h44;
  localparam tLoadChar CharDel   = 7'h7f;

  typedef enum logic [1:0] {
    sLetter,
    sSpace,
    sFields,
    sIgnore
  } tDecState;

  tDecState   state;
  logic       fieldOpen;
  tLoadWord   pending;
  tLoadWord   lineSum;
  tLoadWord   sumWithPending;
  logic       isLf;
  logic       isComma;
  logic       isPrintable;
  logic       takeLetter;
  logic       emitWord;
  tRecordKind letterKind;
  logic       wordValidQ;
  tLoadWord   wordQ;
  logic       lastQ;

  always_comb begin
    isLf = charIn.ch == CharLf;
    isComma = charIn.ch == CharComma;
    // CR, tabs and spaces never carry data
    isPrintable = (charIn.ch > CharSpace) && (charIn.ch < CharDel);
    takeLetter = charIn.valid && state == sLetter && isPrintable;
    // Comma always closes a field, LF only when one is open
    emitWord = charIn.valid && state == sFields && (isComma || (isLf && fieldOpen));
    sumWithPending = lineSum + pending;
    case (charIn.ch)
      CharC:   letterKind = recCram;
      CharD:   letterKind = recDram;
      default: letterKind = recSkip;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line framing

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sLetter;
      fieldOpen <= 1'b0;
      lineStart <= 1'b0;
      lineKind <= recSkip;
      wordValidQ <= 1'b0;
    end else begin
      lineStart <= takeLetter;
      wordValidQ <= emitWord;
      if (takeLetter) begin
        lineKind <= letterKind;
        fieldOpen <= 1'b0;
        // Comment lines and unknown letters run to LF untouched
        state <= (letterKind == recSkip) ? sIgnore : sSpace;
      end else if (charIn.valid) begin
        case (state)
          // Separator after the letter
          sSpace:  state <= isLf ? sLetter : sFields;
          sFields: begin
            if (isLf) begin
              state <= sLetter;
            end else if (isPrintable) begin
              // A comma opens the next field as well
              fieldOpen <= 1'b1;
            end
          end
          sIgnore: if (isLf) state <= sLetter;
          default: state <= sLetter;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word accumulation and running sum

  always_ff @(posedge clk) begin
    if (takeLetter) begin
      pending <= '0;
      lineSum <= '0;
    end else if (emitWord) begin
      pending <= '0;
      lineSum <= sumWithPending;
    end else if (charIn.valid && state == sFields && isPrintable) begin
      // Six bits per character with the oldest bits falling off the top
      pending <= {pending[9:0], charIn.ch[5:0]};
    end
    if (emitWord) begin
      wordQ <= pending;
      lastQ <= isLf;
      // Negated checksum makes the full line sum zero
      checksumOk <= sumWithPending == '0;
    end
  end

  assign wordOut = '{valid: wordValidQ, word: wordQ, lastInLine: lastQ};

  // Nothing follows the last word of a line until the next letter
  assert property (@(posedge clk) disable iff (reset)
    (wordOut.valid && wordOut.lastInLine) |=> !wordOut.valid);

endmodule

// ==== logic/klLoadPkg.sv ====
// Load stream types: characters, decoded words, CRAM/DRAM write records, line status
package klLoadPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Basic widths

  // One decoded field of a load line
  typedef logic [15:0] tLoadWord;

  // One ASCIIized file character
  typedef logic [6:0] tLoadChar;

  // Control RAM address, 2K locations
  typedef logic [10:0] tCramAddr;

  // Dispatch RAM address, written in even/odd pairs
  typedef logic [8:0] tDramAddr;

  // Control RAM location
  // Bit 0 is the most significant bit, as in the KL10 prints
  typedef logic [0:85] tCramWord;

  // One dispatch RAM location
  typedef struct packed {
    logic [2:0] a;
    logic [2:0] b;
    logic       p;
    // J07..J10 per side, J05 and J06 always zero, J01..J04 common
    logic [9:0] j;
  } tDramEntry;

  // Record letter of a load line
  typedef enum logic [1:0] {
    recCram,
    recDram,
    recSkip
  } tRecordKind;

  ////////////////////////////////////////////////////////////////////////////
  // Stream structs

  // Input character strobe
  typedef struct packed {
    logic     valid;
    tLoadChar ch;
  } tCharStrobe;

  // Decoded word, one per comma or line end
  typedef struct packed {
    logic     valid;
    tLoadWord word;
    logic     lastInLine;
  } tWordStrobe;

  // CRAM location write
  typedef struct packed {
    logic     valid;
    tCramAddr addr;
    tCramWord data;
  } tCramWrite;

  // DRAM pair write, addr is always even
  typedef struct packed {
    logic      valid;
    tDramAddr  addr;
    tDramEntry even;
    tDramEntry odd;
  } tDramWrite;

  // Per line result
  typedef struct packed {
    logic       valid;
    tRecordKind kind;
    logic       checksumError;
    logic       formatError;
  } tLineStatus;

  ////////////////////////////////////////////////////////////////////////////
  // Line layout

  // Words per CRAM location and per DRAM pair
  localparam int CramGroupWords = 6;
  localparam int DramGroupWords = 3;

  // Field phase of the word on the stream
  localparam logic [1:0] FieldAddress  = 2'd0;
  localparam logic [1:0] FieldData     = 2'd1;
  localparam logic [1:0] FieldChecksum = 2'd2;
  localparam logic [1:0] FieldOverflow = 2'd3;

endpackage
